// File: bench/clyde_sva.sv
// Handshake properties for the Clyde-128 top level
// Bound into clyde_top, checked only while out of reset
`timescale 1ns/1ps
`default_nettype none

module clyde_sva (
    input logic clk,
    input logic arst_n,
    input logic busy,
    input logic done
);

    // done is a single-cycle pulse
    done_single_pulse: assert property (
        @(posedge clk) disable iff (!arst_n) done |=> !done
    ) else $error("done high for two cycles in a row");

    // done marks the cycle in which busy has just dropped
    done_with_busy_fall: assert property (
        @(posedge clk) disable iff (!arst_n) done == $fell(busy)
    ) else $error("done and falling busy out of step");

endmodule

bind clyde_top clyde_sva u_sva (
    .clk    (clk),
    .arst_n (arst_n),
    .busy   (busy),
    .done   (done)
);

`default_nettype wire

// File: bench/clyde_model.svh
// Reference model of the Clyde-128 encryption from the cipher rules
// Blocks are flat 128-bit vectors with row i in bits 32*i+31 down to 32*i
// Needs clyde_pkg imported by the including module
`ifndef CLYDE_MODEL_SVH
`define CLYDE_MODEL_SVH

// Rotate one row right by n bits
function automatic logic [ROW_BITS-1:0] rotate_right(input logic [ROW_BITS-1:0] v,
                                                     input int n);
    logic [2*ROW_BITS-1:0] both;
    both = {v, v} >> n;
    return both[ROW_BITS-1:0];
endfunction

// Substitute the low SB_COLS columns, then rotate every row right
function automatic logic [STATE_BITS-1:0] sbox_chunk(input logic [STATE_BITS-1:0] s);
    logic [STATE_BITS-1:0] r;
    logic                  x0, x1, x2, x3;
    logic                  y0, y1, y2, y3;
    r = s;
    for (int c = 0; c < SB_COLS; c++) begin
        x0 = s[c];
        x1 = s[ROW_BITS + c];
        x2 = s[2*ROW_BITS + c];
        x3 = s[3*ROW_BITS + c];
        // Output order follows the cipher definition
        y1 = (x0 & x1) ^ x2;
        y0 = (x3 & x0) ^ x1;
        y3 = (y1 & x3) ^ x0;
        y2 = (y0 & y1) ^ x3;
        r[c]              = y0;
        r[ROW_BITS + c]   = y1;
        r[2*ROW_BITS + c] = y2;
        r[3*ROW_BITS + c] = y3;
    end
    for (int i = 0; i < ROWS; i++) begin
        r[i*ROW_BITS +: ROW_BITS] = rotate_right(r[i*ROW_BITS +: ROW_BITS], SB_COLS);
    end
    return r;
endfunction

// L-box on row pairs 0/1 and 2/3
function automatic logic [STATE_BITS-1:0] lbox_rows(input logic [STATE_BITS-1:0] s);
    logic [STATE_BITS-1:0] r;
    logic [ROW_BITS-1:0]   x;
    logic [ROW_BITS-1:0]   y;
    r = s;
    for (int p = 0; p < 2; p++) begin
        x = s[2*p*ROW_BITS +: ROW_BITS];
        y = s[(2*p+1)*ROW_BITS +: ROW_BITS];
        x = x ^ rotate_right(y, int'(LB_ROT_A));
        // y uses the freshly updated x
        y = y ^ rotate_right(x, int'(LB_ROT_B));
        r[2*p*ROW_BITS +: ROW_BITS]     = x;
        r[(2*p+1)*ROW_BITS +: ROW_BITS] = y;
    end
    return r;
endfunction

// Tweak update with t0 ^ t1 in the low half and t0 in the high half
function automatic logic [STATE_BITS-1:0] phi_update(input logic [STATE_BITS-1:0] t);
    logic [STATE_BITS/2-1:0] t0;
    logic [STATE_BITS/2-1:0] t1;
    t0 = t[STATE_BITS/2-1:0];
    t1 = t[STATE_BITS-1:STATE_BITS/2];
    return {t0, t0 ^ t1};
endfunction

// One step of the W constant LFSR
function automatic logic [3:0] w_next(input logic [3:0] w);
    return {w[2:0], w[3] ^ w[0]};
endfunction

// Full encryption of one block
function automatic logic [STATE_BITS-1:0] encrypt_block(input logic [STATE_BITS-1:0] p,
                                                        input logic [STATE_BITS-1:0] k,
                                                        input logic [STATE_BITS-1:0] t);
    logic [STATE_BITS-1:0] s;
    logic [STATE_BITS-1:0] tw;
    logic [3:0]            w;
    s  = p ^ k ^ t;
    tw = t;
    w  = W_INIT;
    for (int r = 0; r < ROUNDS; r++) begin
        for (int c = 0; c < SB_STEPS; c++) begin
            s = sbox_chunk(s);
        end
        s = lbox_rows(s);
        // W bit i goes into bit 0 of row i
        for (int i = 0; i < ROWS; i++) begin
            s[i*ROW_BITS] = s[i*ROW_BITS] ^ w[i];
        end
        w = w_next(w);
        // Second round of a step closes with the tweakey
        if (r % 2 == 1) begin
            tw = phi_update(tw);
            s  = s ^ k ^ tw;
        end
    end
    return s;
endfunction

`endif

// File: bench/clyde_tb.sv
// Testbench for the Clyde-128 core
// Eight table entries with half fixed and half from $urandom seeded with 98
// Expected ciphertexts come from the reference model header
// Odd entries also get a stray start pulse in the middle of the run
`timescale 1ns/1ps
`default_nettype none

module clyde_tb
    import clyde_pkg::*;
();

    localparam int TABLE_LEN      = 8;
    localparam int RESET_CYCLES   = 8;
    localparam int IDLE_CYCLES    = 3;
    localparam int INJECT_CYCLE   = 23;
    localparam int TIMEOUT_CYCLES = TABLE_LEN * (RUN_CYCLES + 10) + RESET_CYCLES;

    logic                  clk;
    logic                  arst_n;
    logic                  start;
    logic [STATE_BITS-1:0] data_in;
    logic [STATE_BITS-1:0] key;
    logic [STATE_BITS-1:0] tweak;
    logic [STATE_BITS-1:0] data_out;
    logic                  busy;
    logic                  done;

    // Stimulus and expected values
    logic [STATE_BITS-1:0] vec_data   [TABLE_LEN];
    logic [STATE_BITS-1:0] vec_key    [TABLE_LEN];
    logic [STATE_BITS-1:0] vec_tweak  [TABLE_LEN];
    logic [STATE_BITS-1:0] vec_expect [TABLE_LEN];

    int cycle_cnt = 0;

    `include "clyde_model.svh"

    clyde_top uut (
        .clk      (clk),
        .arst_n   (arst_n),
        .start    (start),
        .data_in  (data_in),
        .key      (key),
        .tweak    (tweak),
        .data_out (data_out),
        .busy     (busy),
        .done     (done)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Clock and run limit
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Verification failed");
            $fatal(1, "timeout");
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_value(input string name, input logic [STATE_BITS-1:0] got,
                               input logic [STATE_BITS-1:0] expected);
        if (got !== expected) begin
            $display("** Error: %s is 0x%h, expected 0x%h", name, got, expected);
            $display("Verification failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    function automatic logic [STATE_BITS-1:0] random_block();
        return {$urandom(), $urandom(), $urandom(), $urandom()};
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        int n;
        void'($urandom(98));
        start   = 1'b0;
        data_in = '0;
        key     = '0;
        tweak   = '0;
        arst_n  = 1'b0;

        // Fixed entries
        vec_data[0]  = '0;
        vec_key[0]   = '0;
        vec_tweak[0] = '0;
        vec_data[1]  = '1;
        vec_key[1]   = '1;
        vec_tweak[1] = '1;
        vec_data[2]  = 128'h00000001_00000002_00000004_00000008;
        vec_key[2]   = 128'h80000000_40000000_20000000_10000000;
        vec_tweak[2] = 128'h00000000_00000000_00000000_00000001;
        vec_data[3]  = 128'h01020408_10204080_01020408_10204080;
        vec_key[3]   = 128'h00000000_00000000_00000000_00000000;
        vec_tweak[3] = 128'h80000000_00000000_00000000_00000000;
        // Random entries
        for (int e = 4; e < TABLE_LEN; e++) begin
            vec_data[e]  = random_block();
            vec_key[e]   = random_block();
            vec_tweak[e] = random_block();
        end
        for (int e = 0; e < TABLE_LEN; e++) begin
            vec_expect[e] = encrypt_block(vec_data[e], vec_key[e], vec_tweak[e]);
        end

        repeat (RESET_CYCLES) @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        check_value("busy", STATE_BITS'(busy), '0);
        check_value("done", STATE_BITS'(done), '0);
        check_value("data_out", data_out, '0);

        for (int e = 0; e < TABLE_LEN; e++) begin
            @(posedge clk);
            start   <= 1'b1;
            data_in <= vec_data[e];
            key     <= vec_key[e];
            tweak   <= vec_tweak[e];
            // Accepting edge
            @(posedge clk);
            start <= 1'b0;
            n = 0;
            @(negedge clk);
            while (!done) begin
                check_value("busy", STATE_BITS'(busy), STATE_BITS'(1));
                if (n > RUN_CYCLES + 2) begin
                    $display("done did not arrive within %0d cycles of start",
                             RUN_CYCLES + 2);
                    $display("Verification failed");
                    $fatal(1, "missing done");
                end
                @(posedge clk);
                n++;
                // Stray start with other data and tweak while key stays held
                if (e % 2 == 1 && n == INJECT_CYCLE) begin
                    start   <= 1'b1;
                    data_in <= ~vec_data[e];
                    tweak   <= ~vec_tweak[e];
                end else begin
                    start <= 1'b0;
                end
                @(negedge clk);
            end
            check_value("done latency", STATE_BITS'(n), STATE_BITS'(RUN_CYCLES));
            check_value("busy", STATE_BITS'(busy), '0);
            check_value("data_out", data_out, vec_expect[e]);
            // Result must hold while idle
            for (int i = 0; i < IDLE_CYCLES; i++) begin
                @(negedge clk);
                check_value("done", STATE_BITS'(done), '0);
                check_value("busy", STATE_BITS'(busy), '0);
                check_value("data_out", data_out, vec_expect[e]);
            end
        end

        $display("Verification passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: design/clyde_ctrl.sv
// Round sequencer for the Clyde-128 core
// start is only taken while idle, a start during a run is dropped
// Commands are combinational from the counters and start
`timescale 1ns/1ps
`default_nettype none

module clyde_ctrl
    import clyde_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  logic       start,
    output logic       busy,
    output logic       done,
    clyde_ctrl_if.ctrl cmd
);

    // Position inside the round, SB_STEPS marks the L-box cycle
    logic [CHUNK_CNT_BITS-1:0] chunk_cnt;
    // Round index, odd rounds close a step
    logic [ROUND_CNT_BITS-1:0] round_cnt;
    logic                      lbox_phase;
    logic                      last_round;
    logic                      run_end;

    assign lbox_phase = (chunk_cnt == CHUNK_CNT_BITS'(SB_STEPS));
    assign last_round = (round_cnt == ROUND_CNT_BITS'(ROUNDS - 1));

    ////////////////////////////////////////////////////////////////////////////
    // Command decode
    ////////////////////////////////////////////////////////////////////////////

    assign cmd.load   = start & ~busy;
    assign cmd.sbox   = busy & ~lbox_phase;
    assign cmd.lbox   = busy & lbox_phase;
    // Tweakey goes in at the end of the second round of every step
    assign cmd.tk_add = cmd.lbox & round_cnt[0];

    // L-box edge of the final round ends the run
    assign run_end = cmd.lbox & last_round;

    ////////////////////////////////////////////////////////////////////////////
    // Counters and status flags
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy      <= 1'b0;
            done      <= 1'b0;
            chunk_cnt <= '0;
            round_cnt <= '0;
        end else begin
            // One-cycle pulse, coincides with busy falling
            done <= run_end;
            if (cmd.load) begin
                busy      <= 1'b1;
                chunk_cnt <= '0;
                round_cnt <= '0;
            end else if (busy) begin
                if (lbox_phase) begin
                    chunk_cnt <= '0;
                    round_cnt <= last_round ? '0 : round_cnt + 1'b1;
                end else begin
                    chunk_cnt <= chunk_cnt + 1'b1;
                end
                if (run_end) begin
                    busy <= 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: design/clyde_ctrl_if.sv
// Per-cycle datapath commands from the controller
// At most one of load, sbox and lbox is high in a cycle
// tk_add is only ever high together with lbox
`timescale 1ns/1ps
`default_nettype none

interface clyde_ctrl_if;

    // Take the input block, seed tweak and W
    logic load;
    // Substitute one column chunk and rotate it out
    logic sbox;
    // L-box layer plus W addition
    logic lbox;
    // Advance the tweak and add the tweakey
    logic tk_add;

    // Controller side
    modport ctrl (
        output load,
        output sbox,
        output lbox,
        output tk_add
    );

    // Datapath side
    modport dp (
        input load,
        input sbox,
        input lbox,
        input tk_add
    );

endinterface

`default_nettype wire

// File: design/clyde_datapath.sv
// Clyde-128 state register and next-state selection
// Input block, key and tweak are taken on the load command
// data_out is the raw state, only meaningful once busy has dropped
`timescale 1ns/1ps
`default_nettype none

module clyde_datapath
    import clyde_pkg::*;
(
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic [STATE_BITS-1:0] data_in,
    input  logic [STATE_BITS-1:0] key,
    input  logic [STATE_BITS-1:0] tweak,
    clyde_ctrl_if.dp              cmd,
    output logic [STATE_BITS-1:0] data_out
);

    state_t          state_q;
    state_t          state_d;
    state_t          sbox_out;
    state_t          lbox_out;
    state_t          tk_value;
    logic [ROWS-1:0] w_value;

    ////////////////////////////////////////////////////////////////////////////
    // Round layers and key schedule
    ////////////////////////////////////////////////////////////////////////////

    clyde_sbox_layer u_sbox (
        .state_in  (state_q),
        .state_out (sbox_out)
    );

    clyde_lbox_layer u_lbox (
        .state_in  (state_q),
        .state_out (lbox_out)
    );

    clyde_tweakey u_tweakey (
        .clk      (clk),
        .arst_n   (arst_n),
        .tweak    (tweak),
        .key      (key),
        .cmd      (cmd),
        .tk_value (tk_value),
        .w_value  (w_value)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Next state
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        state_d = state_q;
        if (cmd.load) begin
            // Initial tweakey whitening
            state_d = state_t'(data_in ^ key ^ tweak);
        end else if (cmd.sbox) begin
            state_d = sbox_out;
        end else if (cmd.lbox) begin
            state_d = lbox_out;
            // W bit i into bit 0 of row i
            for (int i = 0; i < ROWS; i++) begin
                state_d[i][0] = state_d[i][0] ^ w_value[i];
            end
            if (cmd.tk_add) begin
                state_d = state_d ^ tk_value;
            end
        end
    end

    // Reset value doubles as the idle output after reset
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= '0;
        end else begin
            state_q <= state_d;
        end
    end

    assign data_out = state_q;

endmodule

`default_nettype wire

// File: design/clyde_lbox_layer.sv
// Clyde L-box layer over both row pairs in one cycle
// Pairs are rows 0/1 and rows 2/3, combinational only
`timescale 1ns/1ps
`default_nettype none

module clyde_lbox_layer
    import clyde_pkg::*;
(
    input  state_t state_in,
    output state_t state_out
);

    // Rotate a row right
    function automatic row_t rotr(input row_t v, input logic [4:0] n);
        return (v >> n) | (v << (ROW_BITS - int'(n)));
    endfunction

    row_t x_new [2];
    row_t y_new [2];

    always_comb begin
        for (int p = 0; p < 2; p++) begin
            // x mixes in the partner row first
            x_new[p] = state_in[2*p] ^ rotr(state_in[2*p+1], LB_ROT_A);
            // y then mixes in the already updated x
            y_new[p] = state_in[2*p+1] ^ rotr(x_new[p], LB_ROT_B);

            state_out[2*p]   = x_new[p];
            state_out[2*p+1] = y_new[p];
        end
    end

endmodule

`default_nettype wire

// File: design/clyde_pkg.sv
// Sizes, schedule constants and state types for the Clyde-128 core
// Encryption only, unmasked, one block in flight at a time
// Rows are the four 32-bit words of the block with row 0 in the low bits
`default_nettype none

package clyde_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Block geometry
    ////////////////////////////////////////////////////////////////////////////

    localparam int STATE_BITS = 128;
    localparam int ROW_BITS   = 32;
    localparam int ROWS       = 4;

    ////////////////////////////////////////////////////////////////////////////
    // Round schedule
    ////////////////////////////////////////////////////////////////////////////

    // S-box layer is split into column chunks, one chunk per cycle
    localparam int SB_STEPS     = 4;
    localparam int SB_COLS      = ROW_BITS / SB_STEPS;
    // One extra cycle per round for the L-box layer
    localparam int ROUND_CYCLES = SB_STEPS + 1;
    // A step is two rounds, the tweakey is added after each step
    localparam int STEPS        = 6;
    localparam int ROUNDS       = 2 * STEPS;
    localparam int RUN_CYCLES   = ROUNDS * ROUND_CYCLES;

    // Chunk counter runs 0 to SB_STEPS, round counter 0 to ROUNDS-1
    localparam int CHUNK_CNT_BITS = 3;
    localparam int ROUND_CNT_BITS = 4;

    // W round-constant LFSR seed
    localparam logic [3:0] W_INIT = 4'd1;

    // L-box rotation amounts
    localparam logic [4:0] LB_ROT_A = 5'd12;
    localparam logic [4:0] LB_ROT_B = 5'd3;

    ////////////////////////////////////////////////////////////////////////////
    // State types
    ////////////////////////////////////////////////////////////////////////////

    typedef logic [ROW_BITS-1:0] row_t;
    // Packed so the state maps straight onto a 128-bit block
    typedef row_t [ROWS-1:0] state_t;

endpackage

`default_nettype wire

// File: design/clyde_sbox_layer.sv
// One serial step of the Clyde S-box layer, purely combinational
// Only the low SB_COLS columns are substituted per call
// Rows rotate right by SB_COLS so SB_STEPS calls restore column order
`timescale 1ns/1ps
`default_nettype none

module clyde_sbox_layer
    import clyde_pkg::*;
(
    input  state_t state_in,
    output state_t state_out
);

    // Bitsliced column chunk, x[i] comes from row i
    logic [SB_COLS-1:0] x [ROWS];
    logic [SB_COLS-1:0] y [ROWS];

    always_comb begin
        for (int i = 0; i < ROWS; i++) begin
            x[i] = state_in[i][SB_COLS-1:0];
        end

        // Evaluation order matters, later outputs reuse earlier ones
        y[1] = (x[0] & x[1]) ^ x[2];
        y[0] = (x[3] & x[0]) ^ x[1];
        y[3] = (y[1] & x[3]) ^ x[0];
        y[2] = (y[0] & y[1]) ^ x[3];

        // Substituted chunk lands on top, next chunk drops into the low bits
        for (int i = 0; i < ROWS; i++) begin
            state_out[i] = {y[i], state_in[i][ROW_BITS-1:SB_COLS]};
        end
    end

endmodule

`default_nettype wire

// File: design/clyde_top.sv
// Clyde-128 tweakable block cipher core, encryption only
// start is a one-cycle strobe, ignored while busy is high
// key must be held from start until done
// done pulses once, data_out holds the result until the next start
`timescale 1ns/1ps
`default_nettype none

module clyde_top
    import clyde_pkg::*;
(
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  start,
    input  logic [STATE_BITS-1:0] data_in,
    input  logic [STATE_BITS-1:0] key,
    input  logic [STATE_BITS-1:0] tweak,
    output logic [STATE_BITS-1:0] data_out,
    output logic                  busy,
    output logic                  done
);

    // Command bundle between sequencer and datapath
    clyde_ctrl_if cmd_if ();

    clyde_ctrl u_ctrl (
        .clk    (clk),
        .arst_n (arst_n),
        .start  (start),
        .busy   (busy),
        .done   (done),
        .cmd    (cmd_if.ctrl)
    );

    clyde_datapath u_datapath (
        .clk      (clk),
        .arst_n   (arst_n),
        .data_in  (data_in),
        .key      (key),
        .tweak    (tweak),
        .cmd      (cmd_if.dp),
        .data_out (data_out)
    );

endmodule

`default_nettype wire

// File: design/clyde_tweakey.sv
// Tweak schedule and W round constants for Clyde-128
// key is read combinationally and must stay stable for the whole run
// tk_value already holds the tweak after this cycle's phi update
`timescale 1ns/1ps
`default_nettype none

module clyde_tweakey
    import clyde_pkg::*;
(
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic [STATE_BITS-1:0] tweak,
    input  logic [STATE_BITS-1:0] key,
    clyde_ctrl_if.dp              cmd,
    output state_t                tk_value,
    output logic [ROWS-1:0]       w_value
);

    logic [STATE_BITS-1:0] tweak_q;
    logic [STATE_BITS-1:0] tweak_phi;
    // One W bit per row
    logic [ROWS-1:0]       w_q;

    // phi with t0 low and t1 high gives {t0, t0 ^ t1}
    assign tweak_phi = {tweak_q[STATE_BITS/2-1:0],
                        tweak_q[STATE_BITS/2-1:0] ^ tweak_q[STATE_BITS-1:STATE_BITS/2]};

    always_ff @(posedge clk) begin
        if (cmd.load) begin
            tweak_q <= tweak;
        end else if (cmd.tk_add) begin
            tweak_q <= tweak_phi;
        end
    end

    // W LFSR steps once per round at the L-box cycle
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            w_q <= W_INIT;
        end else if (cmd.load) begin
            w_q <= W_INIT;
        end else if (cmd.lbox) begin
            w_q <= {w_q[2:0], w_q[3] ^ w_q[0]};
        end
    end

    assign tk_value = state_t'(key ^ tweak_phi);
    assign w_value  = w_q;

endmodule

`default_nettype wire

// File: list.f
+incdir+bench
design/clyde_pkg.sv
design/clyde_ctrl_if.sv
design/clyde_ctrl.sv
design/clyde_sbox_layer.sv
design/clyde_lbox_layer.sv
design/clyde_tweakey.sv
design/clyde_datapath.sv
design/clyde_top.sv
bench/clyde_sva.sv
bench/clyde_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the Clyde-128 simulation with Verilator
# Exit status is nonzero when the testbench or an assertion fails
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f list.f --top-module clyde_tb -Mdir obj_dir
./obj_dir/Vclyde_tb
